/* build.f */
riscv_sv32_pkg.sv
mmu_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_fetch_xlate.sv
mmu_data_xlate.sv
mmu_top.sv
tb_axil_mem.sv
tb_mmu.sv

/* mmu_data_xlate.sv */
`timescale 1ns/1ns

module mmu_data_xlate (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              lsu_req_i,
  input  logic [31:0]                       lsu_vaddr_i,
  input  logic                              lsu_is_store_i,
  input  logic                              en_ld_st_translation_i,
  input  riscv_sv32_pkg::priv_lvl_t         ld_st_priv_lvl_i,
  input  logic                              sum_i,
  input  logic                              mxr_i,
  input  mmu_pkg::tlb_lu_t                  dtlb_lu_i,
  input  mmu_pkg::ptw_status_t              ptw_status_i,
  output logic                              dtlb_miss_o,
  output logic                              lsu_dtlb_hit_o,
  output logic                              lsu_valid_o,
  output logic [riscv_sv32_pkg::PLEN-1:0]   lsu_paddr_o,
  output mmu_pkg::exception_t               lsu_exception_o
);

  logic                   lsu_req_q;
  logic                   dtlb_hit_q;
  logic [31:0]            lsu_vaddr_q;
  logic                   lsu_is_store_q;
  logic                   is_4m_q;
  riscv_sv32_pkg::pte_t   pte_q;
  logic                   daccess_err;

  // cycle 0: lookup
  assign lsu_dtlb_hit_o = en_ld_st_translation_i ? dtlb_lu_i.hit : 1'b1;
  assign dtlb_miss_o    = lsu_req_i && en_ld_st_translation_i && !dtlb_lu_i.hit;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lsu_req_q  <= 1'b0;
      dtlb_hit_q <= 1'b0;
    end else begin
      lsu_req_q  <= lsu_req_i;
      dtlb_hit_q <= dtlb_lu_i.hit;
    end
  end

  always_ff @(posedge clk_i) begin
    lsu_vaddr_q    <= lsu_vaddr_i;
    lsu_is_store_q <= lsu_is_store_i;
    is_4m_q        <= dtlb_lu_i.is_4m;
    pte_q          <= dtlb_lu_i.pte;
  end

  // ----------------------------------------
  // cycle 1: address and faults
  // ----------------------------------------
  // supervisor needs sum to touch user pages
  assign daccess_err = ((ld_st_priv_lvl_i == riscv_sv32_pkg::PRIV_S) && pte_q.u && !sum_i)
                    || ((ld_st_priv_lvl_i == riscv_sv32_pkg::PRIV_U) && !pte_q.u);

  always_comb begin
    lsu_valid_o     = lsu_req_q;
    lsu_paddr_o     = {2'b00, lsu_vaddr_q};
    lsu_exception_o = '0;

    if (en_ld_st_translation_i) begin
      lsu_valid_o = 1'b0;
      lsu_paddr_o = {pte_q.ppn1, pte_q.ppn0, lsu_vaddr_q[11:0]};
      if (is_4m_q) begin
        lsu_paddr_o[21:12] = lsu_vaddr_q[21:12];
      end

      if (lsu_req_q && dtlb_hit_q) begin
        lsu_valid_o = 1'b1;
        if (lsu_is_store_q && (!pte_q.w || !pte_q.d || daccess_err)) begin
          lsu_exception_o.valid = 1'b1;
          lsu_exception_o.cause = riscv_sv32_pkg::CAUSE_STORE_PAGE_FAULT;
          lsu_exception_o.tval  = lsu_vaddr_q;
        end else if (!lsu_is_store_q
                     && (!(pte_q.r || (pte_q.x && mxr_i)) || daccess_err)) begin
          lsu_exception_o.valid = 1'b1;
          lsu_exception_o.cause = riscv_sv32_pkg::CAUSE_LOAD_PAGE_FAULT;
          lsu_exception_o.tval  = lsu_vaddr_q;
        end
      end else if (lsu_req_q && ptw_status_i.active && !ptw_status_i.walking_instr
                   && (ptw_status_i.error || ptw_status_i.access_err)) begin
        // a failed walk still completes the request
        lsu_valid_o           = 1'b1;
        lsu_exception_o.valid = 1'b1;
        lsu_exception_o.tval  = ptw_status_i.bad_vaddr;
        if (ptw_status_i.error) begin
          lsu_exception_o.cause = lsu_is_store_q ? riscv_sv32_pkg::CAUSE_STORE_PAGE_FAULT
                                                 : riscv_sv32_pkg::CAUSE_LOAD_PAGE_FAULT;
        end else begin
          lsu_exception_o.cause = lsu_is_store_q ? riscv_sv32_pkg::CAUSE_ST_ACCESS_FAULT
                                                 : riscv_sv32_pkg::CAUSE_LD_ACCESS_FAULT;
        end
      end
    end
  end

endmodule

/* mmu_fetch_xlate.sv */
`timescale 1ns/1ns

module mmu_fetch_xlate (
  input  mmu_pkg::fetch_req_t           fetch_req_i,
  output mmu_pkg::fetch_rsp_t           fetch_rsp_o,
  input  logic                          enable_translation_i,
  input  riscv_sv32_pkg::priv_lvl_t     priv_lvl_i,
  input  mmu_pkg::tlb_lu_t              itlb_lu_i,
  input  mmu_pkg::ptw_status_t          ptw_status_i,
  output logic                          itlb_miss_o
);

  logic iaccess_err;

  assign itlb_miss_o = fetch_req_i.fetch_req && enable_translation_i && !itlb_lu_i.hit;

  // user bit must agree with the privilege level, x must be set
  assign iaccess_err = ((priv_lvl_i == riscv_sv32_pkg::PRIV_U) && !itlb_lu_i.pte.u)
                    || ((priv_lvl_i == riscv_sv32_pkg::PRIV_S) && itlb_lu_i.pte.u)
                    || !itlb_lu_i.pte.x;

  always_comb begin
    // bare mode passes straight through
    fetch_rsp_o.fetch_valid     = fetch_req_i.fetch_req;
    fetch_rsp_o.fetch_paddr     = {2'b00, fetch_req_i.fetch_vaddr};
    fetch_rsp_o.fetch_exception = '0;

    if (enable_translation_i) begin
      fetch_rsp_o.fetch_valid = 1'b0;
      fetch_rsp_o.fetch_paddr = {itlb_lu_i.pte.ppn1, itlb_lu_i.pte.ppn0,
                                 fetch_req_i.fetch_vaddr[11:0]};
      if (itlb_lu_i.is_4m) begin
        fetch_rsp_o.fetch_paddr[21:12] = fetch_req_i.fetch_vaddr[21:12];
      end

      if (itlb_lu_i.hit) begin
        fetch_rsp_o.fetch_valid = fetch_req_i.fetch_req;
        if (iaccess_err) begin
          fetch_rsp_o.fetch_exception.valid = 1'b1;
          fetch_rsp_o.fetch_exception.cause = riscv_sv32_pkg::CAUSE_INSTR_PAGE_FAULT;
          fetch_rsp_o.fetch_exception.tval  = fetch_req_i.fetch_vaddr;
        end
      end else if (ptw_status_i.active && ptw_status_i.walking_instr
                   && (ptw_status_i.error || ptw_status_i.access_err)) begin
        // walk of our own miss failed
        fetch_rsp_o.fetch_valid           = fetch_req_i.fetch_req;
        fetch_rsp_o.fetch_exception.valid = 1'b1;
        fetch_rsp_o.fetch_exception.cause = ptw_status_i.error
                                          ? riscv_sv32_pkg::CAUSE_INSTR_PAGE_FAULT
                                          : riscv_sv32_pkg::CAUSE_INSTR_ACCESS_FAULT;
        fetch_rsp_o.fetch_exception.tval  = fetch_req_i.fetch_vaddr;
      end
    end
  end

endmodule

/* mmu_pkg.sv */
package mmu_pkg;

  typedef struct packed {
    logic                                valid;
    logic [5:0]                          cause;
    logic [riscv_sv32_pkg::XLEN-1:0]     tval;
  } exception_t;

  // ----------------------------------------
  // instruction fetch port
  // ----------------------------------------
  typedef struct packed {
    logic                                fetch_req;
    logic [riscv_sv32_pkg::VLEN-1:0]     fetch_vaddr;
  } fetch_req_t;

  typedef struct packed {
    logic                                fetch_valid;
    logic [riscv_sv32_pkg::PLEN-1:0]     fetch_paddr;
    exception_t                          fetch_exception;
  } fetch_rsp_t;

  // ----------------------------------------
  // tlb refill and lookup
  // ----------------------------------------
  typedef struct packed {
    logic                                valid;
    logic                                is_4m;
    logic [2*riscv_sv32_pkg::VPN_W-1:0]  vpn;
    logic [riscv_sv32_pkg::ASID_W-1:0]   asid;
    riscv_sv32_pkg::pte_t                pte;
  } tlb_update_t;

  typedef struct packed {
    logic                                hit;
    logic                                is_4m;
    riscv_sv32_pkg::pte_t                pte;
  } tlb_lu_t;

  // ----------------------------------------
  // axi4-lite read channels
  // ----------------------------------------
  typedef struct packed {
    logic                                arvalid;
    logic [riscv_sv32_pkg::PLEN-1:0]     araddr;
    logic [2:0]                          arprot;
  } axil_ar_t;

  typedef struct packed {
    logic                                rvalid;
    logic [31:0]                         rdata;
    logic [1:0]                          rresp;
  } axil_r_t;

  // walk result seen by both translators
  typedef struct packed {
    logic                                active;
    logic                                walking_instr;
    logic                                error;
    logic                                access_err;
    logic [riscv_sv32_pkg::VLEN-1:0]     bad_vaddr;
  } ptw_status_t;

endpackage

/* mmu_ptw.sv */
`timescale 1ns/1ns

module mmu_ptw (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                flush_i,
  input  logic                                enable_translation_i,
  input  logic                                en_ld_st_translation_i,
  input  logic                                itlb_miss_i,
  input  logic                                dtlb_miss_i,
  input  logic [31:0]                         fetch_vaddr_i,
  input  logic [31:0]                         lsu_vaddr_i,
  input  logic                                lsu_is_store_i,
  input  logic [riscv_sv32_pkg::PPN_W-1:0]    satp_ppn_i,
  input  logic [riscv_sv32_pkg::ASID_W-1:0]   asid_i,
  output mmu_pkg::tlb_update_t                itlb_update_o,
  output mmu_pkg::tlb_update_t                dtlb_update_o,
  output mmu_pkg::ptw_status_t                status_o,
  output mmu_pkg::axil_ar_t                   axil_ar_o,
  input  logic                                axil_arready_i,
  input  mmu_pkg::axil_r_t                    axil_r_i,
  output logic                                axil_rready_o
);

  typedef enum logic [1:0] {IDLE, L1_RD, L0_RD, DONE} state_e;

  state_e                               state_q;
  logic [31:0]                          vaddr_q;
  logic                                 is_instr_q;
  logic                                 is_store_q;
  logic [riscv_sv32_pkg::ASID_W-1:0]    asid_q;
  logic [riscv_sv32_pkg::PLEN-1:0]      araddr_q;
  logic                                 arvalid_q;
  logic                                 flush_q;
  logic                                 err_q;
  logic                                 acc_err_q;
  mmu_pkg::tlb_update_t                 upd_q;
  riscv_sv32_pkg::pte_t                 pte;
  logic                                 r_fire;

  assign pte    = riscv_sv32_pkg::pte_t'(axil_r_i.rdata);
  assign r_fire = axil_r_i.rvalid && axil_rready_o;

  // ----------------------------------------
  // walk fsm
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      vaddr_q    <= '0;
      is_instr_q <= 1'b0;
      is_store_q <= 1'b0;
      asid_q     <= '0;
      araddr_q   <= '0;
      arvalid_q  <= 1'b0;
      flush_q    <= 1'b0;
      err_q      <= 1'b0;
      acc_err_q  <= 1'b0;
      upd_q      <= '0;
    end else begin
      upd_q.valid <= 1'b0;
      // a flush mid-walk drops the refill of that walk
      if (flush_i && (state_q != IDLE)) begin
        flush_q <= 1'b1;
      end
      if (arvalid_q && axil_arready_i) begin
        arvalid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          flush_q   <= 1'b0;
          err_q     <= 1'b0;
          acc_err_q <= 1'b0;
          // data side has priority
          if (dtlb_miss_i && en_ld_st_translation_i) begin
            state_q    <= L1_RD;
            is_instr_q <= 1'b0;
            is_store_q <= lsu_is_store_i;
            vaddr_q    <= lsu_vaddr_i;
            asid_q     <= asid_i;
            araddr_q   <= {satp_ppn_i, lsu_vaddr_i[31:22], 2'b00};
            arvalid_q  <= 1'b1;
          end else if (itlb_miss_i && enable_translation_i) begin
            state_q    <= L1_RD;
            is_instr_q <= 1'b1;
            is_store_q <= 1'b0;
            vaddr_q    <= fetch_vaddr_i;
            asid_q     <= asid_i;
            araddr_q   <= {satp_ppn_i, fetch_vaddr_i[31:22], 2'b00};
            arvalid_q  <= 1'b1;
          end
        end
        L1_RD, L0_RD: begin
          if (r_fire) begin
            state_q <= DONE;
            if (axil_r_i.rresp != 2'b00) begin
              acc_err_q <= 1'b1;
            end else if (!pte.v || (pte.w && !pte.r)) begin
              err_q <= 1'b1;
            end else if (pte.r || pte.x) begin
              // leaf: misaligned megapage, accessed and dirty checks
              if (((state_q == L1_RD) && (pte.ppn0 != '0)) || !pte.a
                  || (is_store_q && !pte.d)) begin
                err_q <= 1'b1;
              end else begin
                upd_q.valid <= !(flush_q || flush_i);
                upd_q.is_4m <= (state_q == L1_RD);
                upd_q.vpn   <= vaddr_q[31:12];
                upd_q.asid  <= asid_q;
                upd_q.pte   <= pte;
              end
            end else if (state_q == L1_RD) begin
              state_q   <= L0_RD;
              araddr_q  <= {pte.ppn1, pte.ppn0, vaddr_q[21:12], 2'b00};
              arvalid_q <= 1'b1;
            end else begin
              // pointer at the last level
              err_q <= 1'b1;
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  always_comb begin
    itlb_update_o       = upd_q;
    itlb_update_o.valid = upd_q.valid && is_instr_q;
    dtlb_update_o       = upd_q;
    dtlb_update_o.valid = upd_q.valid && !is_instr_q;
  end

  assign status_o.active        = (state_q != IDLE);
  assign status_o.walking_instr = is_instr_q;
  assign status_o.error         = err_q;
  assign status_o.access_err    = acc_err_q;
  assign status_o.bad_vaddr     = vaddr_q;

  // privileged data access
  assign axil_ar_o.arvalid = arvalid_q;
  assign axil_ar_o.araddr  = araddr_q;
  assign axil_ar_o.arprot  = 3'b001;
  assign axil_rready_o     = ((state_q == L1_RD) || (state_q == L0_RD)) && !arvalid_q;

  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (axil_ar_o.arvalid && !axil_arready_i)
      |=> (axil_ar_o.arvalid && $stable(axil_ar_o.araddr)))
    else $error("ptw: read address changed before arready");

endmodule

/* mmu_tlb.sv */
`timescale 1ns/1ns

module mmu_tlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  mmu_pkg::tlb_update_t                  update_i,
  input  logic                                  lu_access_i,
  input  logic [31:0]                           lu_vaddr_i,
  input  logic [riscv_sv32_pkg::ASID_W-1:0]     lu_asid_i,
  output mmu_pkg::tlb_lu_t                      lu_o
);

  localparam int unsigned IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;
  localparam int unsigned VPN_W = riscv_sv32_pkg::VPN_W;

  logic [TLB_ENTRIES-1:0]              valid_q;
  logic [TLB_ENTRIES-1:0]              is_4m_q;
  logic [2*VPN_W-1:0]                  vpn_q  [TLB_ENTRIES];
  logic [riscv_sv32_pkg::ASID_W-1:0]   asid_q [TLB_ENTRIES];
  riscv_sv32_pkg::pte_t                pte_q  [TLB_ENTRIES];
  logic [IDX_W-1:0]                    ptr_q;
  logic [TLB_ENTRIES-1:0]              hit_vec;

  // ----------------------------------------
  // lookup
  // ----------------------------------------
  always_comb begin
    lu_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // vpn0 is a don't care for megapages, g matches any asid
      hit_vec[i] = valid_q[i]
                 && (vpn_q[i][2*VPN_W-1:VPN_W] == lu_vaddr_i[31:22])
                 && (is_4m_q[i] || (vpn_q[i][VPN_W-1:0] == lu_vaddr_i[21:12]))
                 && ((asid_q[i] == lu_asid_i) || pte_q[i].g);
    end
    lu_o.hit = lu_access_i && (|hit_vec);
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (hit_vec[i]) begin
        lu_o.is_4m = is_4m_q[i];
        lu_o.pte   = pte_q[i];
      end
    end
  end

  // ----------------------------------------
  // refill and flush
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      ptr_q   <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      valid_q[ptr_q] <= 1'b1;
      // round robin victim
      if (ptr_q == IDX_W'(TLB_ENTRIES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_i.valid) begin
      is_4m_q[ptr_q] <= update_i.is_4m;
      vpn_q[ptr_q]   <= update_i.vpn;
      asid_q[ptr_q]  <= update_i.asid;
      pte_q[ptr_q]   <= update_i.pte;
    end
  end

  // the walker refills only after a miss, so a page never lands twice
  a_onehot_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lu_access_i |-> $onehot0(hit_vec))
    else $error("tlb: more than one entry hits");

endmodule

/* mmu_top.sv */
`timescale 1ns/1ns

module mmu_top #(
  parameter int unsigned ITLB_ENTRIES = 4,
  parameter int unsigned DTLB_ENTRIES = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // fetch
  input  mmu_pkg::fetch_req_t                 fetch_req_i,
  output mmu_pkg::fetch_rsp_t                 fetch_rsp_o,
  // load/store
  input  logic                                lsu_req_i,
  input  logic [31:0]                         lsu_vaddr_i,
  input  logic                                lsu_is_store_i,
  output logic                                lsu_dtlb_hit_o,
  output logic                                lsu_valid_o,
  output logic [riscv_sv32_pkg::PLEN-1:0]     lsu_paddr_o,
  output mmu_pkg::exception_t                 lsu_exception_o,
  // csr side
  input  logic                                enable_translation_i,
  input  logic                                en_ld_st_translation_i,
  input  riscv_sv32_pkg::priv_lvl_t           priv_lvl_i,
  input  riscv_sv32_pkg::priv_lvl_t           ld_st_priv_lvl_i,
  input  logic                                sum_i,
  input  logic                                mxr_i,
  input  logic [riscv_sv32_pkg::PPN_W-1:0]    satp_ppn_i,
  input  logic [riscv_sv32_pkg::ASID_W-1:0]   asid_i,
  input  logic                                flush_tlb_i,
  // axi4-lite read manager
  output mmu_pkg::axil_ar_t                   axil_ar_o,
  input  logic                                axil_arready_i,
  input  mmu_pkg::axil_r_t                    axil_r_i,
  output logic                                axil_rready_o
);

  mmu_pkg::tlb_lu_t      itlb_lu;
  mmu_pkg::tlb_lu_t      dtlb_lu;
  mmu_pkg::tlb_update_t  itlb_update;
  mmu_pkg::tlb_update_t  dtlb_update;
  mmu_pkg::ptw_status_t  ptw_status;
  logic                  itlb_miss;
  logic                  dtlb_miss;

  mmu_tlb #(.TLB_ENTRIES(ITLB_ENTRIES)) itlb_i (
    .clk_i, .rst_ni,
    .flush_i     (flush_tlb_i),
    .update_i    (itlb_update),
    .lu_access_i (fetch_req_i.fetch_req),
    .lu_vaddr_i  (fetch_req_i.fetch_vaddr),
    .lu_asid_i   (asid_i),
    .lu_o        (itlb_lu)
  );

  mmu_tlb #(.TLB_ENTRIES(DTLB_ENTRIES)) dtlb_i (
    .clk_i, .rst_ni,
    .flush_i     (flush_tlb_i),
    .update_i    (dtlb_update),
    .lu_access_i (lsu_req_i),
    .lu_vaddr_i  (lsu_vaddr_i),
    .lu_asid_i   (asid_i),
    .lu_o        (dtlb_lu)
  );

  mmu_ptw ptw_i (
    .clk_i, .rst_ni,
    .flush_i       (flush_tlb_i),
    .enable_translation_i, .en_ld_st_translation_i,
    .itlb_miss_i   (itlb_miss),
    .dtlb_miss_i   (dtlb_miss),
    .fetch_vaddr_i (fetch_req_i.fetch_vaddr),
    .lsu_vaddr_i, .lsu_is_store_i, .satp_ppn_i, .asid_i,
    .itlb_update_o (itlb_update),
    .dtlb_update_o (dtlb_update),
    .status_o      (ptw_status),
    .axil_ar_o, .axil_arready_i, .axil_r_i, .axil_rready_o
  );

  mmu_fetch_xlate fetch_xlate_i (
    .fetch_req_i, .fetch_rsp_o, .enable_translation_i, .priv_lvl_i,
    .itlb_lu_i    (itlb_lu),
    .ptw_status_i (ptw_status),
    .itlb_miss_o  (itlb_miss)
  );

  mmu_data_xlate data_xlate_i (
    .clk_i, .rst_ni,
    .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .en_ld_st_translation_i,
    .ld_st_priv_lvl_i, .sum_i, .mxr_i,
    .dtlb_lu_i    (dtlb_lu),
    .ptw_status_i (ptw_status),
    .dtlb_miss_o  (dtlb_miss),
    .lsu_dtlb_hit_o, .lsu_valid_o, .lsu_paddr_o, .lsu_exception_o
  );

endmodule

/* riscv_sv32_pkg.sv */
package riscv_sv32_pkg;

  // ----------------------------------------
  // architectural widths
  // ----------------------------------------
  localparam int unsigned XLEN      = 32;
  localparam int unsigned VLEN      = 32;
  localparam int unsigned PLEN      = 34;
  localparam int unsigned PPN_W     = 22;
  localparam int unsigned VPN_W     = 10;
  localparam int unsigned PG_OFFS_W = 12;
  localparam int unsigned ASID_W    = 9;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01
  } priv_lvl_t;

  // sv32 page table entry
  typedef struct packed {
    logic [11:0] ppn1;
    logic [9:0]  ppn0;
    logic [1:0]  rsw;
    logic        d;
    logic        a;
    logic        g;
    logic        u;
    logic        x;
    logic        w;
    logic        r;
    logic        v;
  } pte_t;

  // exception cause codes
  localparam logic [5:0] CAUSE_INSTR_ACCESS_FAULT = 6'd1;
  localparam logic [5:0] CAUSE_LD_ACCESS_FAULT    = 6'd5;
  localparam logic [5:0] CAUSE_ST_ACCESS_FAULT    = 6'd7;
  localparam logic [5:0] CAUSE_INSTR_PAGE_FAULT   = 6'd12;
  localparam logic [5:0] CAUSE_LOAD_PAGE_FAULT    = 6'd13;
  localparam logic [5:0] CAUSE_STORE_PAGE_FAULT   = 6'd15;

endpackage

/* tb_axil_mem.sv */
`timescale 1ns/1ns

module tb_axil_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  mmu_pkg::axil_ar_t   ar_i,
  output logic                arready_o,
  output mmu_pkg::axil_r_t    r_o,
  input  logic                rready_i
);

  // reads at or above this address answer with SLVERR
  localparam logic [33:0] ERR_BASE = 34'h2_0000;

  typedef enum logic {AR_WAIT, R_WAIT} state_e;

  logic [31:0] mem [0:2047];
  state_e      state_q;
  logic [2:0]  delay_q;
  logic [33:0] addr_q;
  integer      seed = 69701;

  function automatic logic [2:0] next_delay();
    next_delay = 3'($unsigned($random(seed)) % 5);
  endfunction

  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    make_pte = {ppn, 2'b00, flags};
  endfunction

  task automatic write_word(input logic [33:0] addr, input logic [31:0] data);
    mem[addr[12:2]] = data;
  endtask

  // ----------------------------------------
  // page tables, root at 0x10000 and level 0 at 0x11000
  // ----------------------------------------
  initial begin
    // fill with invalid entries, v stays clear
    for (int i = 0; i < 2048; i++) begin
      mem[i] = {i[10:0], 21'h0};
    end
    mem[1]      = make_pte(22'h011, 8'h01);
    mem[2]      = make_pte({12'h005, 10'h0}, 8'h49);
    mem[3]      = make_pte({12'h006, 10'h0}, 8'h69);
    mem[4]      = 32'h0;
    mem[5]      = make_pte(22'h020, 8'h01);
    mem[1024+2] = make_pte(22'h345, 8'hc7);
    mem[1024+3] = make_pte(22'h346, 8'hc3);
    mem[1024+4] = make_pte(22'h347, 8'hd7);
    mem[1024+5] = make_pte(22'h777, 8'hc7);
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= AR_WAIT;
      delay_q   <= 3'd2;
      addr_q    <= '0;
      arready_o <= 1'b0;
      r_o       <= '0;
    end else begin
      case (state_q)
        AR_WAIT: begin
          if (ar_i.arvalid && arready_o) begin
            arready_o <= 1'b0;
            addr_q    <= ar_i.araddr;
            delay_q   <= next_delay();
            state_q   <= R_WAIT;
          end else if (ar_i.arvalid) begin
            if (delay_q == 0) begin
              arready_o <= 1'b1;
            end else begin
              delay_q <= delay_q - 1'b1;
            end
          end
        end
        default: begin
          if (r_o.rvalid && rready_i) begin
            r_o.rvalid <= 1'b0;
            delay_q    <= next_delay();
            state_q    <= AR_WAIT;
          end else if (!r_o.rvalid) begin
            if (delay_q == 0) begin
              r_o.rvalid <= 1'b1;
              r_o.rdata  <= mem[addr_q[12:2]];
              r_o.rresp  <= (addr_q >= ERR_BASE) ? 2'b10 : 2'b00;
            end else begin
              delay_q <= delay_q - 1'b1;
            end
          end
        end
      endcase
    end
  end

endmodule

/* tb_mmu.sv */
`timescale 1ns/1ns

module tb_mmu;

  localparam int MAX_CYCLES = 4000;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  mmu_pkg::fetch_req_t fetch_req;
  mmu_pkg::fetch_rsp_t fetch_rsp;
  logic lsu_req_i, lsu_is_store_i, lsu_dtlb_hit_o, lsu_valid_o;
  logic [31:0] lsu_vaddr_i;
  logic [33:0] lsu_paddr_o;
  mmu_pkg::exception_t lsu_exception_o;
  logic en_i, en_ls_i, sum_i, mxr_i, flush_i;
  riscv_sv32_pkg::priv_lvl_t priv_i, ls_priv_i;
  logic [21:0] satp_ppn_i;
  logic [8:0] asid_i;
  mmu_pkg::axil_ar_t ar;
  mmu_pkg::axil_r_t r;
  logic arready, rready;
  // expected result and first-cycle lookup checks
  logic [33:0] exp_paddr;
  logic exp_exc, chk_hit, chk_miss;
  logic [5:0] exp_cause;
  logic [31:0] exp_tval;
  int errors = 0;
  int cycles = 0;

  always #5 clk_i = ~clk_i;

  mmu_top #(.ITLB_ENTRIES(4), .DTLB_ENTRIES(4)) dut_i (
    .clk_i, .rst_ni, .fetch_req_i(fetch_req), .fetch_rsp_o(fetch_rsp),
    .lsu_req_i, .lsu_vaddr_i, .lsu_is_store_i, .lsu_dtlb_hit_o, .lsu_valid_o,
    .lsu_paddr_o, .lsu_exception_o, .enable_translation_i(en_i),
    .en_ld_st_translation_i(en_ls_i), .priv_lvl_i(priv_i), .ld_st_priv_lvl_i(ls_priv_i),
    .sum_i, .mxr_i, .satp_ppn_i, .asid_i, .flush_tlb_i(flush_i),
    .axil_ar_o(ar), .axil_arready_i(arready), .axil_r_i(r), .axil_rready_o(rready)
  );

  tb_axil_mem mem_i (.clk_i, .rst_ni, .ar_i(ar), .arready_o(arready), .r_o(r), .rready_i(rready));

  task automatic log_failure(input string msg);
    errors++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  function automatic bit result_ok(input logic [33:0] paddr, input mmu_pkg::exception_t ex,
                                   input logic [33:0] e_paddr, input logic e_exc,
                                   input logic [5:0] e_cause, input logic [31:0] e_tval);
    if (e_exc) begin
      return ex.valid && (ex.cause == e_cause) && (ex.tval == e_tval);
    end
    return !ex.valid && (paddr == e_paddr);
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_bare_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_i |-> (fetch_rsp.fetch_valid == fetch_req.fetch_req) && !fetch_rsp.fetch_exception.valid
      && (fetch_rsp.fetch_paddr == {2'b00, fetch_req.fetch_vaddr}))
    else log_failure("fetch not passed through with translation off");
  a_bare_lsu: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_req_i && !en_ls_i) |=> lsu_valid_o && !lsu_exception_o.valid
      && (lsu_paddr_o == {2'b00, $past(lsu_vaddr_i)}))
    else log_failure("load not passed through one cycle later with translation off");
  a_bare_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_ls_i |-> lsu_dtlb_hit_o) else log_failure("dtlb hit not forced with translation off");
  a_hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_req_i && lsu_dtlb_hit_o) |=> lsu_valid_o) else log_failure("no result after dtlb hit");
  a_valid_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_valid_o |-> $past(lsu_req_i)) else log_failure("lsu result without a request");
  a_lsu_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lsu_valid_o && en_ls_i) |-> result_ok(lsu_paddr_o, lsu_exception_o, exp_paddr, exp_exc,
                                           exp_cause, exp_tval))
    else log_failure("wrong load/store address or exception");
  a_fetch_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_rsp.fetch_valid && en_i) |-> result_ok(fetch_rsp.fetch_paddr,
      fetch_rsp.fetch_exception, exp_paddr, exp_exc, exp_cause, exp_tval))
    else log_failure("wrong fetch address or exception");
  a_first_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_hit |-> (lsu_req_i ? lsu_dtlb_hit_o : fetch_rsp.fetch_valid))
    else log_failure("expected a tlb hit in the request cycle");
  a_first_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_miss |-> (lsu_req_i ? !lsu_dtlb_hit_o : !fetch_rsp.fetch_valid))
    else log_failure("expected a tlb miss in the request cycle");
  // page table reads are privileged data accesses
  a_ar_prot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar.arvalid |-> (ar.arprot[0] && !ar.arprot[2]))
    else log_failure("page table read not marked as a privileged data access");

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic expect_result(input logic [33:0] pa, input logic exc, input logic [5:0] cause,
                               input logic [31:0] tval);
    exp_paddr = pa;
    exp_exc   = exc;
    exp_cause = cause;
    exp_tval  = tval;
  endtask

  // first picks the request-cycle check as none (0), hit (1) or miss (2)
  task automatic lsu_access(input logic [31:0] va, input logic st, input int first);
    lsu_vaddr_i = va;
    lsu_is_store_i = st;
    lsu_req_i = 1'b1;
    chk_hit = (first == 1);
    chk_miss = (first == 2);
    do begin
      @(posedge clk_i);
      #1;
      chk_hit = 1'b0;
      chk_miss = 1'b0;
    end while (!lsu_valid_o);
    lsu_req_i = 1'b0;
    // the result is sampled on the next rising edge
    @(posedge clk_i);
    #1;
  endtask

  task automatic fetch_access(input logic [31:0] va, input int first);
    logic got;
    fetch_req.fetch_vaddr = va;
    fetch_req.fetch_req = 1'b1;
    chk_hit = (first == 1);
    chk_miss = (first == 2);
    do begin
      @(negedge clk_i);
      got = fetch_rsp.fetch_valid;
      @(posedge clk_i);
      #1;
      chk_hit = 1'b0;
      chk_miss = 1'b0;
    end while (!got);
    fetch_req.fetch_req = 1'b0;
  endtask

  initial begin
    fetch_req = '0;
    {lsu_req_i, lsu_is_store_i, en_i, en_ls_i, sum_i, mxr_i, flush_i} = '0;
    {chk_hit, chk_miss} = '0;
    lsu_vaddr_i = '0;
    priv_i = riscv_sv32_pkg::PRIV_S;
    ls_priv_i = riscv_sv32_pkg::PRIV_S;
    satp_ppn_i = 22'h010;
    asid_i = 9'd1;
    expect_result('0, 1'b0, '0, '0);
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // translation off
    fetch_access(32'h1234_5678, 0);
    lsu_access(32'h0000_1004, 1'b0, 0);
    @(posedge clk_i);
    #1;
    en_i = 1'b1;
    en_ls_i = 1'b1;
    // 4k data page misses and then hits
    expect_result(34'h345abc, 1'b0, '0, '0);
    lsu_access(32'h0040_2abc, 1'b0, 2);
    lsu_access(32'h0040_2abc, 1'b0, 1);
    // megapage fetch and asid tagging
    expect_result(34'h141_2344, 1'b0, '0, '0);
    fetch_access(32'h0081_2344, 2);
    fetch_access(32'h0081_2344, 1);
    asid_i = 9'd2;
    fetch_access(32'h0081_2344, 2);
    asid_i = 9'd1;
    expect_result(34'h180_1000, 1'b0, '0, '0);
    fetch_access(32'h00c0_1000, 2);
    asid_i = 9'd3;
    fetch_access(32'h00c0_1000, 1);
    asid_i = 9'd1;
    // permission faults
    expect_result('0, 1'b1, riscv_sv32_pkg::CAUSE_STORE_PAGE_FAULT, 32'h0040_3010);
    lsu_access(32'h0040_3010, 1'b1, 2);
    expect_result('0, 1'b1, riscv_sv32_pkg::CAUSE_LOAD_PAGE_FAULT, 32'h0040_4020);
    lsu_access(32'h0040_4020, 1'b0, 2);
    sum_i = 1'b1;
    expect_result(34'h347020, 1'b0, '0, '0);
    lsu_access(32'h0040_4020, 1'b0, 1);
    expect_result('0, 1'b1, riscv_sv32_pkg::CAUSE_INSTR_PAGE_FAULT, 32'h0100_0100);
    fetch_access(32'h0100_0100, 2);
    // bus errors on the level 0 read
    expect_result('0, 1'b1, riscv_sv32_pkg::CAUSE_LD_ACCESS_FAULT, 32'h0140_0200);
    lsu_access(32'h0140_0200, 1'b0, 2);
    expect_result('0, 1'b1, riscv_sv32_pkg::CAUSE_ST_ACCESS_FAULT, 32'h0140_0200);
    lsu_access(32'h0140_0200, 1'b1, 2);
    // remap a page, flush and translate again
    expect_result(34'h777008, 1'b0, '0, '0);
    lsu_access(32'h0040_5008, 1'b0, 2);
    lsu_access(32'h0040_5008, 1'b0, 1);
    mem_i.write_word(34'h1_1014, {22'h888, 10'h0c7});
    flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
    expect_result(34'h888008, 1'b0, '0, '0);
    lsu_access(32'h0040_5008, 1'b0, 2);
    repeat (5) @(posedge clk_i);
    $display("closing: %0d failed checks, 0 timeouts, %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("closing: %0d failed checks, 1 timeouts, %0d cycles", errors, cycles);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule
